// ==== bench/engine_tb.sv ====
//////////////////////////////////////////////////
// testbench for the thread queue: stimulus,
// queue model, output comparison and timeout
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "engine_params.svh"

module engine_tb
    import thread_pkg::*;
    import window_pkg::*;
;

    localparam int FIFO_DEPTH     = 1 << `ENGINE_FIFO_DEPTH_LOG2;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_CYCLES  = 300;
    localparam int FILL_THREADS   = 3 * NUM_LANES;
    localparam int MASK_CYCLES    = 40;
    localparam int HOLD_CYCLES    = 6;
    // worst case to empty every lane, plus a held input
    localparam int DRAIN_CYCLES   = NUM_LANES * FIFO_DEPTH + 4;
    localparam int STIM_CYCLES    = RESET_CYCLES + RANDOM_CYCLES + FILL_THREADS + MASK_CYCLES
                                    + FIFO_DEPTH + HOLD_CYCLES + 4 * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic       clk = 1'b0;
    logic       rst;
    logic       running;
    logic       full;
    lane_mask_t elaborating_chars;
    lane_mask_t cur_window_enable;
    logic       new_char;
    logic       input_pc_valid;
    thread_t    input_pc;
    logic       input_pc_ready;
    latency_t   input_pc_latency;
    logic       output_pc_valid;
    thread_t    output_pc;
    logic       output_pc_ready;

    integer     seed = 28731;
    int         error_count = 0;
    int         cycle_count = 0;
    int         rst_edges = 0;
    // traffic counters for the end of run
    int         full_seen = 0;
    int         blocked_seen = 0;
    int         masked_seen = 0;
    // set by the driver at each edge
    bit         idle_at_edge;

    // queue model, one queue per lane
    thread_t    lane_q [NUM_LANES][$];
    int         model_ptr;
    latency_t   model_latency;

    engine engine_i (
        .clk               (clk              ),
        .rst               (rst              ),
        .running           (running          ),
        .full              (full             ),
        .elaborating_chars (elaborating_chars),
        .cur_window_enable (cur_window_enable),
        .new_char          (new_char         ),
        .input_pc_valid    (input_pc_valid   ),
        .input_pc          (input_pc         ),
        .input_pc_ready    (input_pc_ready   ),
        .input_pc_latency  (input_pc_latency ),
        .output_pc_valid   (output_pc_valid  ),
        .output_pc         (output_pc        ),
        .output_pc_ready   (output_pc_ready  )
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // checking helpers and reference model
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            error_count++;
            $display("ERROR %s expected 0x%0h got 0x%0h", name, exp, got);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond)
        else
        begin
            error_count++;
            $display("check failed: %s", what);
            $display("Testbench failed");
            $fatal(1, "check failed");
        end
    endtask

    // first enabled non-empty lane after the pointer or -1 when there is none
    function automatic int predict_grant(input lane_mask_t nonempty, input lane_mask_t enable,
                                         input int ptr);
        int lane;
        int found;
        found = -1;
        for (int off = 1; off <= NUM_LANES; off++)
        begin
            lane = (ptr + off) % NUM_LANES;
            if (found < 0 && nonempty[lane] && enable[lane])
            begin
                found = lane;
            end
        end
        return found;
    endfunction

    //////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////

    // samples at the edge, before any register moves
    always @(posedge clk)
    begin : monitor
        lane_mask_t nonempty;
        lane_mask_t lane_full;
        int         gl;
        bit         in_xfer;
        bit         out_xfer;
        if (rst)
        begin
            // registers are only defined after the first reset edge
            if (rst_edges > 0)
            begin
                check_value("output_pc_valid", 16'(output_pc_valid), 16'h0);
                check_value("full", 16'(full), 16'h0);
                check_value("running", 16'(running), 16'h0);
                check_value("elaborating_chars", 16'(elaborating_chars), 16'h0);
                check_value("input_pc_ready", 16'(input_pc_ready), 16'h1);
                check_value("input_pc_latency", 16'(input_pc_latency), 16'h1);
            end
            rst_edges++;
            for (int l = 0; l < NUM_LANES; l++)
            begin
                lane_q[l].delete();
            end
            model_ptr     = NUM_LANES - 1;
            model_latency = latency_t'(1);
        end
        else
        begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
                nonempty[l]  = (lane_q[l].size() != 0);
                lane_full[l] = (lane_q[l].size() == FIFO_DEPTH);
            end
            check_value("elaborating_chars", 16'(elaborating_chars), 16'(nonempty));
            check_value("full", 16'(full), 16'(lane_full != '0));
            check_value("input_pc_ready", 16'(input_pc_ready), 16'(lane_full == '0));
            check_value("running", 16'(running), 16'((nonempty & cur_window_enable) != '0));
            check_value("input_pc_latency", 16'(input_pc_latency), 16'(model_latency));
            gl = predict_grant(nonempty, cur_window_enable, model_ptr);
            check_value("output_pc_valid", 16'(output_pc_valid), 16'(gl >= 0));
            if (gl >= 0)
            begin
                check_value("output_pc", 16'(output_pc), 16'(lane_q[gl][0]));
            end
            in_xfer  = input_pc_valid && (lane_full == '0);
            out_xfer = (gl >= 0) && output_pc_ready;
            // pop before push since a pop only ever takes an entry older than this edge
            if (out_xfer)
            begin
                void'(lane_q[gl].pop_front());
            end
            if (in_xfer)
            begin
                lane_q[input_pc.cc_id].push_back(input_pc);
            end
            if (in_xfer && !out_xfer)
            begin
                model_latency = model_latency + latency_t'(1);
            end
            else if (out_xfer && !in_xfer)
            begin
                model_latency = model_latency - latency_t'(1);
            end
            if (new_char)
            begin
                model_ptr = (model_ptr + 1) % NUM_LANES;
            end
            // coverage of the interesting states
            if (lane_full != '0)
            begin
                full_seen++;
            end
            if (input_pc_valid && !in_xfer)
            begin
                blocked_seen++;
            end
            if ((nonempty & ~cur_window_enable) != '0)
            begin
                masked_seen++;
            end
        end
    end

    // hard stop if the queue never drains
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // one clock of input; a thread not yet taken stays on the bus
    // lane below zero picks a random lane
    task automatic drive_cycle(input bit offer, input int lane, input bit pulse_char,
                               input bit out_ready);
        bit      taken;
        thread_t t;
        @(posedge clk);
        taken        = input_pc_valid && input_pc_ready;
        idle_at_edge = (elaborating_chars == '0) && !input_pc_valid;
        #1;
        new_char        = pulse_char;
        output_pc_ready = out_ready;
        if (!(input_pc_valid && !taken))
        begin
            if (offer)
            begin
                t.pc = pc_t'($random(seed));
                if (lane < 0)
                begin
                    t.cc_id = lane_t'($random(seed));
                end
                else
                begin
                    t.cc_id = lane_t'(lane);
                end
                input_pc       = t;
                input_pc_valid = 1'b1;
            end
            else
            begin
                input_pc_valid = 1'b0;
            end
        end
    endtask

    // output open until every lane and the input bus are empty
    task automatic drain_all(input bit random_char);
        idle_at_edge = 1'b0;
        while (!idle_at_edge)
        begin
            drive_cycle(1'b0, -1, random_char && (($random(seed) & 3) == 0), 1'b1);
        end
    endtask

    initial
    begin
        rst               = 1'b1;
        input_pc_valid    = 1'b0;
        input_pc          = '0;
        output_pc_ready   = 1'b0;
        cur_window_enable = '1;
        new_char          = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // random lanes with the output always ready
        repeat (RANDOM_CYCLES)
        begin
            drive_cycle(($random(seed) & 1) != 0, -1, 1'b0, 1'b1);
        end
        drain_all(1'b0);

        // fill every lane with output stalled, then drain with rotating priority
        for (int n = 0; n < FILL_THREADS; n++)
        begin
            drive_cycle(1'b1, n % NUM_LANES, 1'b0, 1'b0);
        end
        drain_all(1'b1);

        // lanes 1 and 3 outside the window
        cur_window_enable = 4'b0101;
        repeat (MASK_CYCLES)
        begin
            drive_cycle(($random(seed) & 1) != 0, -1, 1'b0, 1'b1);
        end
        cur_window_enable = '1;
        drain_all(1'b0);

        // lane 2 filled with the output stalled, then a lane 1 thread must wait
        repeat (FIFO_DEPTH)
        begin
            drive_cycle(1'b1, 2, 1'b0, 1'b0);
        end
        repeat (HOLD_CYCLES)
        begin
            drive_cycle(1'b1, 1, 1'b0, 1'b0);
        end
        drain_all(1'b0);

        check_true(full_seen > 0, "full never went high");
        check_true(blocked_seen > 0, "no input was ever held back");
        check_true(masked_seen > 0, "no disabled lane ever held a thread");
        if (error_count == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== hw/engine.sv ====
//////////////////////////////////////////////////
// thread queue top: dispatcher, one fifo per
// lane and the output arbiter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module engine
    import thread_pkg::*;
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // status
    output logic       running,
    output logic       full,
    output lane_mask_t elaborating_chars,
    input  lane_mask_t cur_window_enable,
    input  logic       new_char,
    // input stream
    input  logic       input_pc_valid,
    input  thread_t    input_pc,
    output logic       input_pc_ready,
    output latency_t   input_pc_latency,
    // output stream
    output logic       output_pc_valid,
    output thread_t    output_pc,
    input  logic       output_pc_ready
);

    // per lane write strobes from the dispatcher
    lane_mask_t fifo_wr_en;
    // per lane pop strobes from the arbiter
    lane_mask_t fifo_rd_en;
    lane_mask_t fifo_full;
    lane_mask_t fifo_not_empty;
    // head entry of each lane
    thread_t    fifo_head [NUM_LANES];

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    thread_dispatch dispatch_i (
        .clk              (clk             ),
        .rst              (rst             ),
        .input_pc_valid   (input_pc_valid  ),
        .input_pc         (input_pc        ),
        .input_pc_ready   (input_pc_ready  ),
        .lane_full        (fifo_full       ),
        .wr_en            (fifo_wr_en      ),
        .full             (full            ),
        .output_pc_valid  (output_pc_valid ),
        .output_pc_ready  (output_pc_ready ),
        .input_pc_latency (input_pc_latency)
    );

    //////////////////////////////////////////////////
    // lane fifos
    //////////////////////////////////////////////////

    // same entry goes to every fifo, wr_en picks the lane
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        thread_fifo fifo_i (
            .clk       (clk              ),
            .rst       (rst              ),
            .din       (input_pc         ),
            .wr_en     (fifo_wr_en[i]    ),
            .rd_en     (fifo_rd_en[i]    ),
            .dout      (fifo_head[i]     ),
            .full      (fifo_full[i]     ),
            .not_empty (fifo_not_empty[i])
        );
    end

    // busy per character, regardless of the window enable
    assign elaborating_chars = fifo_not_empty;

    //////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////

    lane_arbiter arbiter_i (
        .clk             (clk              ),
        .rst             (rst              ),
        .head            (fifo_head        ),
        .head_valid      (fifo_not_empty   ),
        .lane_enable     (cur_window_enable),
        .new_char        (new_char         ),
        .rd_en           (fifo_rd_en       ),
        .output_pc       (output_pc        ),
        .output_pc_valid (output_pc_valid  ),
        .output_pc_ready (output_pc_ready  ),
        .running         (running          )
    );

endmodule

// ==== hw/engine_params.svh ====
//////////////////////////////////////////////////
// sizing macros for the thread queue
// pc width, lane bits, fifo depth, latency width
//////////////////////////////////////////////////
`ifndef ENGINE_PARAMS_SVH
`define ENGINE_PARAMS_SVH

// program counter width of a thread
`define ENGINE_PC_WIDTH 8

// lane identifier width
// number of lanes is 2**ENGINE_CC_ID_BITS
`define ENGINE_CC_ID_BITS 2

// default log2 of entries per lane fifo
// 2 gives 4 entries
`define ENGINE_FIFO_DEPTH_LOG2 2

// width of the running latency estimate
// wraps silently if more threads are in flight than it can count
`define ENGINE_LATENCY_WIDTH 8

`endif

// ==== hw/lane_arbiter.sv ====
//////////////////////////////////////////////////
// masked fixed-priority arbiter over the lane
// fifos, priority rotated by new_char
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lane_arbiter
    import thread_pkg::*;
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  thread_t    head [NUM_LANES],
    input  lane_mask_t head_valid,
    input  lane_mask_t lane_enable,
    input  logic       new_char,
    output lane_mask_t rd_en,
    output thread_t    output_pc,
    output logic       output_pc_valid,
    input  logic       output_pc_ready,
    output logic       running
);

    // lane with the lowest priority
    // search starts at the lane right after it
    lane_t      prio_ptr;
    // heads that may leave this cycle
    lane_mask_t masked_valid;
    // winner of the search
    lane_t      grant_lane;
    logic       grant_found;

    // lanes outside the current window are held back
    assign masked_valid = head_valid & lane_enable;
    assign running      = |masked_valid;

    //////////////////////////////////////////////////
    // priority search
    //////////////////////////////////////////////////

    // walk upward from prio_ptr+1, lane_t arithmetic wraps modulo NUM_LANES
    always_comb
    begin
        lane_t idx;
        grant_lane  = '0;
        grant_found = 1'b0;
        for (int off = 1; off <= NUM_LANES; off++)
        begin
            idx = prio_ptr + lane_t'(off);
            if (masked_valid[idx] && !grant_found)
            begin
                grant_lane  = idx;
                grant_found = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // output and pop
    //////////////////////////////////////////////////

    assign output_pc       = head[grant_lane];
    assign output_pc_valid = grant_found;

    // pop only the granted lane, only on a completed handshake
    always_comb
    begin
        rd_en = '0;
        if (grant_found && output_pc_ready)
        begin
            rd_en[grant_lane] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // priority pointer
    //////////////////////////////////////////////////

    // after reset lane 0 goes first
    // each new character moves the top priority one lane up
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prio_ptr <= lane_t'(NUM_LANES - 1);
        end
        else if (new_char)
        begin
            prio_ptr <= prio_ptr + lane_t'(1);
        end
    end

endmodule

// ==== hw/thread_dispatch.sv ====
//////////////////////////////////////////////////
// input side of the thread queue: lane demux,
// common ready, full flag and latency estimate
//////////////////////////////////////////////////
`timescale 1ns/1ps

module thread_dispatch
    import thread_pkg::*;
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       input_pc_valid,
    input  thread_t    input_pc,
    output logic       input_pc_ready,
    input  lane_mask_t lane_full,
    output lane_mask_t wr_en,
    output logic       full,
    input  logic       output_pc_valid,
    input  logic       output_pc_ready,
    output latency_t   input_pc_latency
);

    // lane of the incoming thread
    lane_t in_lane;
    // handshakes on both ends of the queue
    logic  in_xfer;
    logic  out_xfer;

    assign in_lane = input_pc.cc_id;

    // accept only when every lane has room
    // the target lane is not looked at, this keeps ready off the payload
    assign input_pc_ready = ~(|lane_full);
    assign full           = |lane_full;

    assign in_xfer  = input_pc_valid && input_pc_ready;
    assign out_xfer = output_pc_valid && output_pc_ready;

    //////////////////////////////////////////////////
    // lane demux
    //////////////////////////////////////////////////

    // payload fans out to all fifos, only the selected lane writes
    always_comb
    begin
        wr_en = '0;
        if (in_xfer)
        begin
            wr_en[in_lane] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // latency estimate
    //////////////////////////////////////////////////

    // counts threads in flight, plus one for the new arrival
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            input_pc_latency <= latency_t'(1);
        end
        else
        begin
            case ({in_xfer, out_xfer})
                2'b10:   input_pc_latency <= input_pc_latency + latency_t'(1);
                2'b01:   input_pc_latency <= input_pc_latency - latency_t'(1);
                // both or neither, occupancy unchanged
                default: input_pc_latency <= input_pc_latency;
            endcase
        end
    end

endmodule

// ==== hw/thread_fifo.sv ====
//////////////////////////////////////////////////
// first-word-fall-through fifo of thread entries
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "engine_params.svh"

module thread_fifo
    import thread_pkg::*;
#(
    parameter int DEPTH_LOG2 = `ENGINE_FIFO_DEPTH_LOG2
)(
    input  logic    clk,
    input  logic    rst,
    input  thread_t din,
    input  logic    wr_en,
    input  logic    rd_en,
    output thread_t dout,
    output logic    full,
    output logic    not_empty
);

    localparam int                DEPTH      = 1 << DEPTH_LOG2;
    localparam logic [DEPTH_LOG2:0] FULL_COUNT = (DEPTH_LOG2 + 1)'(DEPTH);

    // storage
    thread_t               mem [DEPTH];
    // pointers wrap on their own, depth is a power of two
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    // one extra bit so that full and empty differ
    logic [DEPTH_LOG2:0]   count;
    // qualified strobes
    logic                  do_wr;
    logic                  do_rd;

    assign full      = (count == FULL_COUNT);
    assign not_empty = (count != '0);

    // write while full and read while empty are dropped here
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && not_empty;

    // head is always on the output, no read latency
    assign dout = mem[rd_ptr];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= din;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/thread_pkg.sv ====
//////////////////////////////////////////////////
// thread types: program counter, thread entry
// and latency estimate
//////////////////////////////////////////////////
`include "engine_params.svh"

package thread_pkg;

    // program counter of one thread
    typedef logic [`ENGINE_PC_WIDTH-1:0] pc_t;

    // one queued thread
    // pc sits in the upper bits, lane id in the lower bits,
    // same layout as a plain {pc, cc_id} concatenation
    typedef struct packed {
        pc_t                           pc;
        logic [`ENGINE_CC_ID_BITS-1:0] cc_id;
    } thread_t;

    // estimate of cycles a new thread waits before leaving the queue
    typedef logic [`ENGINE_LATENCY_WIDTH-1:0] latency_t;

endpackage

// ==== hw/window_pkg.sv ====
//////////////////////////////////////////////////
// character window types: lane index and mask
//////////////////////////////////////////////////
`include "engine_params.svh"

package window_pkg;

    // one lane per character of the window
    localparam int NUM_LANES = 2 ** `ENGINE_CC_ID_BITS;

    // index of a window character
    typedef logic [`ENGINE_CC_ID_BITS-1:0] lane_t;

    // one bit per lane
    // used for enables, fifo status and one-hot strobes
    typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build the thread queue testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=engine_sim
LOG=sim.log

verilator --binary --timing -f tb.f --top-module engine_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// ==== tb.f ====
+incdir+hw
hw/thread_pkg.sv
hw/window_pkg.sv
hw/thread_dispatch.sv
hw/thread_fifo.sv
hw/lane_arbiter.sv
hw/engine.sv
bench/engine_tb.sv
